// File: src.f
+incdir+sim
hw/pkt_pkg.sv
hw/delay_line.sv
hw/checksum_tree.sv
hw/header_builder.sv
hw/stream_rewrapper.sv
hw/pkt_assembler.sv
sim/tb_pkt_assembler.sv

// File: Makefile
TOP = tb_pkt_assembler

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): src.f hw/*.sv sim/*.sv sim/*.svh
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module pkt_assembler

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: sim/tb_vectors.svh
// packet table, one entry per packet in send order
// wr_len, len      length register write before the packet
// wr_hdr, hdr_sel  header build before the packet, raw header from tab_hdr
// beats            input beats of the packet
// last_mask        valid lanes of the final input beat
localparam int pkt_count = 8;
localparam int max_beats = 8;

// raw headers, word 16 first, length and checksum words hold junk on purpose
localparam hdr_t tab_hdr [2] = '{
    272'h00c7_c0a8_0001_c0a8_beef_4011_4000_1c46_dead_4500_0800_4455_2233_0011_4e5f_2c3d_0a1b,
    272'h00fe_0a00_0002_0a00_0000_4006_0000_abcd_0000_4500_0800_0001_5e10_0200_ffff_ffff_ffff
};

localparam bit tab_wr_len [pkt_count] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

localparam len_t tab_len [pkt_count] = '{
    16'h0062, 16'h0000, 16'h05dc, 16'h0000, 16'h0000, 16'h0000, 16'h0400, 16'h0000
};

// packet 2 writes a new length only, so its header must not change
localparam bit tab_wr_hdr [pkt_count] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};

localparam int tab_hdr_sel [pkt_count] = '{0, 0, 0, 1, 0, 0, 0, 0};

localparam int tab_beats [pkt_count] = '{1, 3, 2, 4, 1, 2, 5, 1};

// masks at 15 lanes or fewer need no tail beat
localparam lane_mask_t tab_last_mask [pkt_count] = '{
    32'h0000_7fff, 32'hffff_ffff, 32'h0000_3fff, 32'h0000_ffff,
    32'h0000_ffff, 32'h0000_0001, 32'h0001_ffff, 32'hffff_ffff
};

// File: sim/tb_pkt_assembler.sv
`timescale 1ns/1ps

module tb_pkt_assembler import pkt_pkg::*; ();

    `include "tb_vectors.svh"

    logic       clk;
    logic       rst;
    logic       len_we;
    len_t       len_in;
    logic       hdr_we;
    hdr_t       hdr_in;
    logic       stream_start;
    phit_t      tdata_in;
    lane_mask_t tvalid_in;
    logic       tlast_in;
    phit_t      tdata_out;
    lane_mask_t tvalid_out;
    logic       tlast_out;

    integer seed;

    // reference state: length register and the finished header in use
    len_t len_model;
    hdr_t cur_hdr;
    logic mon_done;

    phit_t      pkt_data  [max_beats];
    lane_mask_t pkt_valid [max_beats];

    phit_t      exp_data_q  [$];
    lane_mask_t exp_valid_q [$];
    logic       exp_last_q  [$];

    pkt_assembler uut (
        .clk          (clk),
        .rst          (rst),
        .len_we       (len_we),
        .len_in       (len_in),
        .hdr_we       (hdr_we),
        .hdr_in       (hdr_in),
        .stream_start (stream_start),
        .tdata_in     (tdata_in),
        .tvalid_in    (tvalid_in),
        .tlast_in     (tlast_in),
        .tdata_out    (tdata_out),
        .tvalid_out   (tvalid_out),
        .tlast_out    (tlast_out)
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_data(input phit_t got, input phit_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s, got %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_valid(input lane_mask_t got, input lane_mask_t exp,
                               input string what);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s, got %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_last(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s, got %b, expected %b",
                                     $time, what, got, exp));
        end
    endtask

    // ipv4 checksum over words 7 to 16, checksum word counted as zero
    function automatic hdr_t finish_header(input hdr_t raw, input len_t len);
        hdr_t        h;
        logic [31:0] acc;
        h = raw;
        h[len_word*lane_bits +: lane_bits] = len;
        acc = '0;
        for (int k = ip_first_word; k < hdr_words; k++) begin
            if (k != csum_word) begin
                acc = acc + 32'(h[k*lane_bits +: lane_bits]);
            end
        end
        while (acc[31:16] != '0) begin
            acc = 32'(acc[15:0]) + 32'(acc[31:16]);
        end
        h[csum_word*lane_bits +: lane_bits] = ~acc[15:0];
        return h;
    endfunction

    function automatic phit_t expand_mask(input lane_mask_t m);
        phit_t bits;
        for (int l = 0; l < simd_lanes; l++) begin
            bits[l*lane_bits +: lane_bits] = {lane_bits{m[l]}};
        end
        return bits;
    endfunction

    // lanes from 15 up spill over into a tail beat
    function automatic int out_beats(input int p);
        if ((tab_last_mask[p] >> carry_lanes) != '0) begin
            return tab_beats[p] + 1;
        end else begin
            return tab_beats[p];
        end
    endfunction

    // output beat n: lanes 0-16 from the header or the upper lanes of beat n-1,
    // lanes 17-31 from the lower lanes of beat n
    task automatic queue_expected(input int p);
        phit_t      ed;
        lane_mask_t ev;
        for (int n = 0; n < out_beats(p); n++) begin
            ed = '0;
            ev = '0;
            for (int l = 0; l < simd_lanes; l++) begin
                if (l < hdr_words && n == 0) begin
                    ed[l*lane_bits +: lane_bits] = cur_hdr[l*lane_bits +: lane_bits];
                    ev[l] = 1'b1;
                end else if (l < hdr_words) begin
                    ed[l*lane_bits +: lane_bits] =
                        pkt_data[n-1][(l+carry_lanes)*lane_bits +: lane_bits];
                    ev[l] = pkt_valid[n-1][l+carry_lanes];
                end else if (n < tab_beats[p]) begin
                    ed[l*lane_bits +: lane_bits] =
                        pkt_data[n][(l-hdr_words)*lane_bits +: lane_bits];
                    ev[l] = pkt_valid[n][l-hdr_words];
                end
            end
            exp_data_q.push_back(ed & expand_mask(ev));
            exp_valid_q.push_back(ev);
            exp_last_q.push_back(n == out_beats(p) - 1);
        end
    endtask

    // length first, header one cycle later, then let the checksum settle
    task automatic write_config(input int p);
        @(posedge clk);
        len_we <= tab_wr_len[p];
        len_in <= tab_len[p];
        @(posedge clk);
        len_we <= 1'b0;
        hdr_we <= tab_wr_hdr[p];
        hdr_in <= tab_hdr[tab_hdr_sel[p]];
        @(posedge clk);
        hdr_we <= 1'b0;
        if (tab_wr_len[p]) begin
            len_model = tab_len[p];
        end
        if (tab_wr_hdr[p]) begin
            cur_hdr = finish_header(tab_hdr[tab_hdr_sel[p]], len_model);
        end
        repeat (7) @(posedge clk);
    endtask

    task automatic send_packet(input int p);
        int beats;
        beats = tab_beats[p];
        for (int n = 0; n < beats; n++) begin
            for (int l = 0; l < simd_lanes; l++) begin
                pkt_data[n][l*lane_bits +: lane_bits] = lane_bits'($random(seed));
            end
            pkt_valid[n] = (n == beats - 1) ? tab_last_mask[p] : '1;
        end
        queue_expected(p);
        for (int n = 0; n < beats; n++) begin
            @(posedge clk);
            stream_start <= (n == 0);
            tdata_in     <= pkt_data[n];
            tvalid_in    <= pkt_valid[n];
            tlast_in     <= (n == beats - 1);
        end
        // one idle cycle, the minimum gap
        @(posedge clk);
        stream_start <= 1'b0;
        tvalid_in    <= '0;
        tlast_in     <= 1'b0;
    endtask

    task automatic wait_beat(input int limit, input int p, input int n);
        int waited;
        waited = 0;
        @(negedge clk);
        while (tvalid_out == '0) begin
            check_last(tlast_out, 1'b0, "tlast_out between beats");
            waited++;
            if (waited >= limit) begin
                report_failure($sformatf("output beat %0d of packet %0d never arrived", n, p));
            end
            @(negedge clk);
        end
    endtask

    task automatic watch_output();
        phit_t      ed;
        lane_mask_t ev;
        logic       el;
        for (int p = 0; p < pkt_count; p++) begin
            for (int n = 0; n < out_beats(p); n++) begin
                // beats inside a packet come back to back
                wait_beat((n == 0) ? 64 : 1, p, n);
                if (exp_valid_q.size() == 0) begin
                    report_failure($sformatf("packet %0d produced a beat before it was sent", p));
                end
                ed = exp_data_q.pop_front();
                ev = exp_valid_q.pop_front();
                el = exp_last_q.pop_front();
                check_valid(tvalid_out, ev, $sformatf("valid, packet %0d beat %0d", p, n));
                check_data(tdata_out & expand_mask(ev), ed,
                           $sformatf("data, packet %0d beat %0d", p, n));
                check_last(tlast_out, el, $sformatf("last, packet %0d beat %0d", p, n));
            end
        end
        mon_done = 1'b1;
    endtask

    initial begin
        int waited;
        seed         = 32'hbad7_24f1;
        clk          = 1'b0;
        rst          = 1'b1;
        len_we       = 1'b0;
        len_in       = '0;
        hdr_we       = 1'b0;
        hdr_in       = '0;
        stream_start = 1'b0;
        tdata_in     = '0;
        tvalid_in    = '0;
        tlast_in     = 1'b0;
        len_model    = '0;
        cur_hdr      = '0;
        mon_done     = 1'b0;

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        repeat (4) begin
            @(negedge clk);
            check_valid(tvalid_out, '0, "tvalid_out after reset");
            check_last(tlast_out, 1'b0, "tlast_out after reset");
        end

        fork
            watch_output();
        join_none

        for (int p = 0; p < pkt_count; p++) begin
            if (tab_wr_len[p] || tab_wr_hdr[p]) begin
                write_config(p);
            end
            send_packet(p);
        end

        waited = 0;
        while (!mon_done) begin
            if (waited >= 64) begin
                report_failure("the output checker did not see every packet in time");
            end
            @(negedge clk);
            waited++;
        end

        // nothing may follow the final packet
        repeat (4) begin
            @(negedge clk);
            check_valid(tvalid_out, '0, "tvalid_out after the final packet");
            check_last(tlast_out, 1'b0, "tlast_out after the final packet");
        end

        $display("Test passed");
        $finish;
    end

endmodule

// File: hw/pkt_assembler.sv
`timescale 1ns/1ps

module pkt_assembler import pkt_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       len_we,
    input  len_t       len_in,
    input  logic       hdr_we,
    input  hdr_t       hdr_in,
    input  logic       stream_start,
    input  phit_t      tdata_in,
    input  lane_mask_t tvalid_in,
    input  logic       tlast_in,
    output phit_t      tdata_out,
    output lane_mask_t tvalid_out,
    output logic       tlast_out
);

    // finished header with length and checksum in place
    hdr_t hdr_out;

    header_builder u_hdr (
        .clk     (clk),
        .rst     (rst),
        .len_we  (len_we),
        .len_in  (len_in),
        .hdr_we  (hdr_we),
        .hdr_in  (hdr_in),
        .hdr_out (hdr_out)
    );

    stream_rewrapper u_wrap (
        .clk          (clk),
        .rst          (rst),
        .hdr          (hdr_out),
        .stream_start (stream_start),
        .tdata_in     (tdata_in),
        .tvalid_in    (tvalid_in),
        .tlast_in     (tlast_in),
        .tdata_out    (tdata_out),
        .tvalid_out   (tvalid_out),
        .tlast_out    (tlast_out)
    );

endmodule

// File: hw/stream_rewrapper.sv
`timescale 1ns/1ps

module stream_rewrapper import pkt_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  hdr_t       hdr,
    input  logic       stream_start,
    input  phit_t      tdata_in,
    input  lane_mask_t tvalid_in,
    input  logic       tlast_in,
    output phit_t      tdata_out,
    output lane_mask_t tvalid_out,
    output logic       tlast_out
);

    typedef enum logic [1:0] {
        st_idle,
        st_body,
        st_tail
    } state_t;

    state_t state;

    // upper lanes of the previous beat wait here for the next output beat
    logic [hdr_bits-1:0]  carry_data;
    logic [hdr_words-1:0] carry_valid;

    // lower lanes of the next output beat
    logic [hdr_bits-1:0]  low_data;
    logic [hdr_words-1:0] low_valid;

    logic beat_in;
    logic tail_pending;

    always_comb begin
        if (state == st_idle) begin
            low_data  = hdr;
            low_valid = '1;
        end else begin
            low_data  = carry_data;
            low_valid = carry_valid;
        end
    end

    // a beat is consumed on every body cycle as packets carry no bubbles
    assign beat_in = (state == st_body) || (state == st_idle && stream_start);

    // any valid lane that does not fit behind the shift needs a tail beat
    assign tail_pending = |tvalid_in[simd_lanes-1:carry_lanes];

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            tvalid_out  <= '0;
            tlast_out   <= 1'b0;
            carry_valid <= '0;
        end else begin
            case (state)
                st_idle, st_body: begin
                    if (beat_in) begin
                        tvalid_out  <= {tvalid_in[carry_lanes-1:0], low_valid};
                        carry_valid <= tvalid_in[simd_lanes-1:carry_lanes];
                        if (tlast_in && tail_pending) begin
                            state     <= st_tail;
                            tlast_out <= 1'b0;
                        end else if (tlast_in) begin
                            state     <= st_idle;
                            tlast_out <= 1'b1;
                        end else begin
                            state     <= st_body;
                            tlast_out <= 1'b0;
                        end
                    end else begin
                        tvalid_out <= '0;
                        tlast_out  <= 1'b0;
                    end
                end
                st_tail: begin
                    // leftover lanes only with the upper part of the beat empty
                    tvalid_out <= {{carry_lanes{1'b0}}, carry_valid};
                    tlast_out  <= 1'b1;
                    state      <= st_idle;
                end
                default: begin
                    state      <= st_idle;
                    tvalid_out <= '0;
                    tlast_out  <= 1'b0;
                end
            endcase
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (state == st_tail) begin
            tdata_out <= {{(carry_lanes*lane_bits){1'b0}}, carry_data};
        end else begin
            tdata_out <= {tdata_in[carry_lanes*lane_bits-1:0], low_data};
        end
        carry_data <= tdata_in[phit_bits-1:carry_lanes*lane_bits];
    end

endmodule

// File: hw/header_builder.sv
`timescale 1ns/1ps

module header_builder import pkt_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic len_we,
    input  len_t len_in,
    input  logic hdr_we,
    input  hdr_t hdr_in,
    output hdr_t hdr_out
);

    len_t  len_reg;
    hdr_t  hdr_len;
    hdr_t  hdr_dly;
    hdr_t  hdr_done;
    csum_t csum;
    logic  build_dly;

    // software-written total length
    always_ff @(posedge clk) begin
        if (rst) begin
            len_reg <= '0;
        end else if (len_we) begin
            len_reg <= len_in;
        end
    end

    // length goes in before the delay so a later write cannot tear the header
    always_comb begin
        hdr_len = hdr_in;
        hdr_len[len_word*lane_bits +: lane_bits] = len_reg;
    end

    checksum_tree u_csum (
        .clk  (clk),
        .rst  (rst),
        .hdr  (hdr_in),
        .len  (len_reg),
        .csum (csum)
    );

    // header and strobe wait for the checksum
    delay_line #(.payload_t(hdr_t), .depth(csum_latency)) u_hdr_dly (
        .clk (clk),
        .rst (rst),
        .d   (hdr_len),
        .q   (hdr_dly)
    );

    delay_line #(.payload_t(logic), .depth(csum_latency)) u_we_dly (
        .clk (clk),
        .rst (rst),
        .d   (hdr_we),
        .q   (build_dly)
    );

    always_comb begin
        hdr_done = hdr_dly;
        hdr_done[csum_word*lane_bits +: lane_bits] = csum;
    end

    // finished header holds until the next build
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_out <= '0;
        end else if (build_dly) begin
            hdr_out <= hdr_done;
        end
    end

endmodule

// File: hw/checksum_tree.sv
`timescale 1ns/1ps

module checksum_tree import pkt_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  hdr_t  hdr,
    input  len_t  len,
    output csum_t csum
);

    // the ten ipv4 header words as they enter the sum
    logic [lane_bits-1:0] words [hdr_words-ip_first_word];

    logic [sum_bits-1:0] s1 [5];
    logic [sum_bits-1:0] s2 [3];
    logic [sum_bits-1:0] s3 [2];

    logic [sum_bits-1:0]  total;
    logic [lane_bits:0]   fold1;
    logic [lane_bits-1:0] fold2;

    // length comes from the register and the checksum field counts as zero
    always_comb begin
        for (int i = 0; i < hdr_words - ip_first_word; i++) begin
            words[i] = hdr[(ip_first_word + i) * lane_bits +: lane_bits];
        end
        words[len_word - ip_first_word]  = len;
        words[csum_word - ip_first_word] = '0;
    end

    // stage 1 adds the ten words in five pairs
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 5; k++) begin
                s1[k] <= '0;
            end
        end else begin
            for (int k = 0; k < 5; k++) begin
                s1[k] <= sum_bits'(words[2*k]) + sum_bits'(words[2*k+1]);
            end
        end
    end

    // stages 2 and 3 where the odd operand rides along in a balancing register
    always_ff @(posedge clk) begin
        if (rst) begin
            s2[0] <= '0;
            s2[1] <= '0;
            s2[2] <= '0;
            s3[0] <= '0;
            s3[1] <= '0;
        end else begin
            s2[0] <= s1[0] + s1[1];
            s2[1] <= s1[2] + s1[3];
            s2[2] <= s1[4];
            s3[0] <= s2[0] + s2[1];
            s3[1] <= s2[2];
        end
    end

    // end-around carry needs only two folds for ten words
    always_comb begin
        total = s3[0] + s3[1];
        fold1 = (lane_bits+1)'(total[lane_bits-1:0])
              + (lane_bits+1)'(total[sum_bits-1:lane_bits]);
        fold2 = fold1[lane_bits-1:0] + lane_bits'(fold1[lane_bits]);
    end

    // stage 4 registers the inverted one's-complement sum
    always_ff @(posedge clk) begin
        if (rst) begin
            csum <= '0;
        end else begin
            csum <= ~fold2;
        end
    end

endmodule

// File: hw/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
    parameter type payload_t = logic,
    parameter int  depth     = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t d,
    output payload_t q
);

    payload_t pipe [depth];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= d;
            for (int i = 1; i < depth; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign q = pipe[depth-1];

endmodule

// File: hw/pkt_pkg.sv
package pkt_pkg;

    // beat geometry
    localparam int lane_bits  = 16;
    localparam int simd_lanes = 32;
    localparam int phit_bits  = lane_bits * simd_lanes;

    // ethernet + ipv4 header, counted in 16-bit words
    localparam int hdr_words = 17;
    localparam int hdr_bits  = hdr_words * lane_bits;

    // lanes of an input beat that land in the same output beat
    localparam int carry_lanes = simd_lanes - hdr_words;

    // word positions inside the header
    localparam int len_word      = 8;
    localparam int csum_word     = 12;
    localparam int ip_first_word = 7;

    // checksum pipeline
    localparam int csum_latency = 4;
    localparam int sum_bits     = 20;

    typedef logic [phit_bits-1:0]  phit_t;
    typedef logic [simd_lanes-1:0] lane_mask_t;
    typedef logic [hdr_bits-1:0]   hdr_t;
    typedef logic [lane_bits-1:0]  len_t;
    typedef logic [lane_bits-1:0]  csum_t;

endpackage
